// File: rvCore.f
hdl/rvCorePkg.sv
hdl/fetchUnit.sv
hdl/decodeUnit.sv
hdl/regFile.sv
hdl/executeUnit.sv
hdl/rvCore.sv
sim/rvCore_props.sv
sim/rvCore_tb.sv

// File: Makefile
TOP = rvCore_tb

.PHONY: all lint clean

all:
	verilator --binary --assert -f rvCore.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q -F '** PASS **'

lint:
	verilator --lint-only --timing --assert -f rvCore.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: sim/rvCore_tb.sv
module rvCore_tb
	import rvCorePkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int timeoutCycles = 400;
	// jal x0, 0
	localparam word selfLoop = 32'h0000006f;

	logic clk;
	logic reset;
	word imemAddr;
	word imemData;
	regWrite wb;

	word imem [0:255];
	regWrite expQ [$];
	integer seed = 32'h99a4b52b;
	int progIdx;
	int errors;
	int checks;
	int tests;
	int testsFailed;

	rvCore #(.resetAddr(32'h0)) u_rvCore (
		.clk(clk),
		.reset(reset),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.wb(wb)
	);

	assign imemData = imem[imemAddr[9:2]];

	always #50 clk = ~clk;

	function automatic word rInstr(input logic [2:0] f3, input logic alt, input regIdx rd,
			input regIdx rs1, input regIdx rs2);
		rInstr = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opReg};
	endfunction

	function automatic word iInstr(input logic [2:0] f3, input regIdx rd, input regIdx rs1,
			input logic [11:0] imm);
		iInstr = {imm, rs1, f3, rd, opImm};
	endfunction

	function automatic word uInstr(input regIdx rd, input logic [19:0] imm);
		uInstr = {imm, rd, opLui};
	endfunction

	function automatic word bInstr(input logic [2:0] f3, input regIdx rs1, input regIdx rs2,
			input logic [12:0] off);
		bInstr = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
	endfunction

	function automatic word jInstr(input regIdx rd, input logic [20:0] off);
		jInstr = {off[20], off[10:1], off[11], off[19:12], rd, opJal};
	endfunction

	function automatic word aluRef(input logic [2:0] f3, input logic alt, input word a,
			input word b);
		case (f3)
			3'd0: aluRef = alt ? a - b : a + b;
			3'd1: aluRef = a << b[4:0];
			3'd2: aluRef = {31'b0, $signed(a) < $signed(b)};
			3'd3: aluRef = {31'b0, a < b};
			3'd4: aluRef = a ^ b;
			3'd5: aluRef = alt ? word'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: aluRef = a | b;
			default: aluRef = a & b;
		endcase
	endfunction

	function automatic logic branchRef(input logic [2:0] f3, input word a, input word b);
		case (f3)
			3'd0: branchRef = a == b;
			3'd1: branchRef = a != b;
			3'd4: branchRef = $signed(a) < $signed(b);
			3'd5: branchRef = $signed(a) >= $signed(b);
			default: branchRef = 1'b0;
		endcase
	endfunction

	// Instruction-set model that stops at the closing self loop
	function automatic void runModel();
		word regs [0:31];
		word pc;
		word nextPc;
		word ins;
		word res;
		logic doWrite;
		int steps;
		regWrite exp;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		pc = '0;
		steps = 0;
		while (imem[pc[9:2]] != selfLoop && steps < 1000) begin
			ins = imem[pc[9:2]];
			res = '0;
			doWrite = 1'b0;
			nextPc = pc + 32'd4;
			case (ins[6:0])
				opReg: begin
					res = aluRef(ins[14:12], ins[30], regs[ins[19:15]], regs[ins[24:20]]);
					doWrite = 1'b1;
				end
				opImm: begin
					res = aluRef(ins[14:12], ins[30] && ins[14:12] == 3'd5, regs[ins[19:15]],
						{{20{ins[31]}}, ins[31:20]});
					doWrite = 1'b1;
				end
				opLui: begin
					res = {ins[31:12], 12'b0};
					doWrite = 1'b1;
				end
				opJal: begin
					res = pc + 32'd4;
					doWrite = 1'b1;
					nextPc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
				end
				opBranch: begin
					if (branchRef(ins[14:12], regs[ins[19:15]], regs[ins[24:20]])) begin
						nextPc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
					end
				end
				default: begin
				end
			endcase
			if (doWrite && ins[11:7] != 5'd0) begin
				regs[ins[11:7]] = res;
				exp.valid = 1'b1;
				exp.rd = ins[11:7];
				exp.data = res;
				expQ.push_back(exp);
			end
			pc = nextPc;
			steps++;
		end
	endfunction

	always @(posedge clk) begin
		regWrite exp;
		if (reset) begin
			assert (wb.valid !== 1'b1) else begin
				errors++;
				$display("Write to x%0d reported during reset at %0t", wb.rd, $time);
			end
		end else if (wb.valid) begin
			assert (expQ.size() != 0) else begin
				errors++;
				$display("Write x%0d = %h at %0t after the last expected write", wb.rd, wb.data,
					$time);
			end
			if (expQ.size() != 0) begin
				exp = expQ.pop_front();
				checks++;
				assert (wb.rd == exp.rd && wb.data == exp.data) else begin
					errors++;
					$display("ERR %0t: expected x%0d = %h, got x%0d = %h", $time, exp.rd, exp.data,
						wb.rd, wb.data);
				end
			end
		end
	end

	// Unused words hold no-ops that differ by address
	function automatic void fillMemory();
		for (int i = 0; i < 256; i++) begin
			imem[i] = iInstr(3'd0, 5'd0, 5'd0, 12'(i));
		end
	endfunction

	task automatic beginProgram();
		@(posedge clk);
		reset <= 1'b1;
		fillMemory();
		progIdx = 0;
	endtask

	function automatic void emit(input word ins);
		imem[progIdx] = ins;
		progIdx++;
	endfunction

	function automatic regIdx pickReg(input logic [3:0] bits);
		pickReg = 5'(bits % 4'd7) + 5'd1;
	endfunction

	task automatic runTest(input string name);
		int cycles;
		int errBefore;
		int checkBefore;
		emit(selfLoop);
		runModel();
		errBefore = errors;
		checkBefore = checks;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		cycles = 0;
		while (expQ.size() != 0 && cycles < timeoutCycles) begin
			@(posedge clk);
			cycles++;
		end
		if (expQ.size() != 0) begin
			errors++;
			$display("%s timed out after %0d cycles, %0d writes never arrived", name, cycles,
				expQ.size());
			expQ.delete();
		end
		// Late squashed writes would land here
		repeat (8) @(posedge clk);
		tests++;
		if (errors != errBefore) begin
			testsFailed++;
		end
		$display("%s: %0d writes checked, %s", name, checks - checkBefore,
			errors == errBefore ? "ok" : "failed");
	endtask

	task automatic regChainTest();
		word r;
		regIdx prev;
		regIdx rd;
		beginProgram();
		for (int i = 1; i < 8; i++) begin
			r = $random(seed);
			emit(uInstr(5'(i), r[31:12]));
			emit(iInstr(3'd0, 5'(i), 5'(i), r[11:0]));
		end
		prev = 5'd7;
		for (int i = 0; i < 24; i++) begin
			r = $random(seed);
			rd = pickReg(r[3:0]);
			emit(rInstr(r[10:8], r[11] && (r[10:8] == 3'd0 || r[10:8] == 3'd5), rd, prev,
				pickReg(r[7:4])));
			prev = rd;
		end
		runTest("register chain");
	endtask

	task automatic immTest();
		word r;
		logic [11:0] imm;
		beginProgram();
		emit(iInstr(3'd0, 5'd1, 5'd0, 12'hffd));
		emit(uInstr(5'd2, 20'h80000));
		// srai by 4 and srli by 31
		emit(iInstr(3'd5, 5'd3, 5'd2, 12'h404));
		emit(iInstr(3'd5, 5'd4, 5'd2, 12'h01f));
		emit(iInstr(3'd1, 5'd5, 5'd1, 12'h01c));
		emit(iInstr(3'd2, 5'd6, 5'd1, 12'hfff));
		emit(iInstr(3'd3, 5'd7, 5'd1, 12'hfff));
		emit(iInstr(3'd4, 5'd1, 5'd3, 12'hf0f));
		emit(iInstr(3'd7, 5'd2, 5'd1, 12'h8f0));
		emit(iInstr(3'd6, 5'd3, 5'd4, 12'h800));
		for (int i = 0; i < 20; i++) begin
			r = $random(seed);
			imm = r[11:0];
			if (r[14:12] == 3'd1) begin
				imm = {7'b0, r[4:0]};
			end else if (r[14:12] == 3'd5) begin
				imm = {1'b0, r[15], 5'b0, r[4:0]};
			end
			emit(iInstr(r[14:12], pickReg(r[19:16]), pickReg(r[23:20]), imm));
		end
		runTest("immediate and lui");
	endtask

	task automatic branchTest();
		logic [2:0] conds [4] = '{3'd0, 3'd1, 3'd4, 3'd5};
		logic [11:0] lhs [8] = '{12'd5, 12'd5, 12'd5, 12'd7, 12'hffd, 12'd2, 12'd2, 12'hffd};
		logic [11:0] rhs [8] = '{12'd5, 12'd6, 12'd6, 12'd7, 12'd2, 12'hffd, 12'hffd, 12'd2};
		beginProgram();
		// Even entries take the branch
		for (int k = 0; k < 8; k++) begin
			emit(iInstr(3'd0, 5'd1, 5'd0, lhs[k]));
			emit(iInstr(3'd0, 5'd2, 5'd0, rhs[k]));
			emit(bInstr(conds[k / 2], 5'd1, 5'd2, 13'd12));
			emit(iInstr(3'd0, 5'd10, 5'd0, 12'h7ad));
			emit(iInstr(3'd0, 5'd11, 5'd0, 12'h5be));
			emit(iInstr(3'd0, 5'd12, 5'd1, 12'(k)));
		end
		runTest("branches");
	endtask

	task automatic jalTest();
		beginProgram();
		emit(iInstr(3'd0, 5'd1, 5'd0, 12'd1));
		emit(jInstr(5'd5, 21'd12));
		emit(iInstr(3'd0, 5'd6, 5'd0, 12'h06a));
		emit(iInstr(3'd0, 5'd7, 5'd0, 12'h06b));
		emit(rInstr(3'd0, 1'b0, 5'd8, 5'd5, 5'd1));
		emit(jInstr(5'd9, 21'd12));
		emit(iInstr(3'd0, 5'd6, 5'd0, 12'h06c));
		emit(iInstr(3'd0, 5'd7, 5'd0, 12'h06d));
		emit(iInstr(3'd0, 5'd10, 5'd9, 12'd4));
		runTest("jal");
	endtask

	task automatic zeroRegTest();
		beginProgram();
		emit(iInstr(3'd0, 5'd0, 5'd0, 12'd123));
		emit(iInstr(3'd0, 5'd1, 5'd0, 12'd7));
		emit(uInstr(5'd0, 20'habcde));
		emit(rInstr(3'd0, 1'b0, 5'd0, 5'd1, 5'd1));
		emit(rInstr(3'd0, 1'b0, 5'd2, 5'd0, 5'd1));
		emit(rInstr(3'd0, 1'b1, 5'd3, 5'd0, 5'd1));
		emit(rInstr(3'd6, 1'b0, 5'd4, 5'd0, 5'd0));
		runTest("x0 writes");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		fillMemory();
		errors = 0;
		checks = 0;
		tests = 0;
		testsFailed = 0;
		beginProgram();
		emit(iInstr(3'd0, 5'd1, 5'd0, 12'h011));
		emit(iInstr(3'd0, 5'd2, 5'd1, 12'h022));
		emit(rInstr(3'd0, 1'b0, 5'd3, 5'd1, 5'd2));
		runTest("reset");
		regChainTest();
		immTest();
		branchTest();
		jalTest();
		zeroRegTest();
		// Bound property failures count as errors too
		errors += u_rvCore.u_rvCoreProps.failCount;
		$display("%0d tests, %0d failed, %0d writes checked, %0d errors", tests, testsFailed,
			checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: sim/rvCore_props.sv
module rvCore_props
	import rvCorePkg::*;
#(
	parameter word resetAddr = '0
) (
	input logic clk,
	input logic reset,
	input word imemAddr,
	input regWrite wb
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;

	// wb register clears on every edge that sees reset
	quietInReset: assert property (@(posedge clk) reset |=> !wb.valid)
		else begin
			failCount++;
			$error("wb.valid high after a reset cycle");
		end

	noX0Write: assert property (@(posedge clk) wb.valid |-> wb.rd != '0)
		else begin
			failCount++;
			$error("write to x0 reported on wb");
		end

	alignedFetch: assert property (@(posedge clk) disable iff (reset) imemAddr[1:0] == 2'b00)
		else begin
			failCount++;
			$error("imemAddr not word aligned");
		end

	firstStep: assert property (@(posedge clk) $fell(reset) |=> imemAddr == resetAddr + 32'd4)
		else begin
			failCount++;
			$error("pc did not step by four from resetAddr");
		end

endmodule

bind rvCore rvCore_props #(.resetAddr(resetAddr)) u_rvCoreProps (
	.clk(clk),
	.reset(reset),
	.imemAddr(imemAddr),
	.wb(wb)
);

// File: hdl/rvCore.sv
module rvCore
	import rvCorePkg::*;
#(
	parameter word resetAddr = '0
) (
	input logic clk,
	input logic reset,
	output word imemAddr,
	input word imemData,
	output regWrite wb
);

	fetchedInstr fetched;
	decodedInstr decoded;
	redirect branchRedirect;
	regIdx rs1Idx;
	regIdx rs2Idx;
	word rs1Val;
	word rs2Val;

	fetchUnit #(.resetAddr(resetAddr)) u_fetchUnit (
		.clk(clk),
		.reset(reset),
		.redirect(branchRedirect),
		.imemData(imemData),
		.imemAddr(imemAddr),
		.fetched(fetched)
	);

	decodeUnit u_decodeUnit (
		.clk(clk),
		.reset(reset),
		.fetched(fetched),
		.redirect(branchRedirect),
		.rs1(rs1Idx),
		.rs2(rs2Idx),
		.rs1Val(rs1Val),
		.rs2Val(rs2Val),
		.decoded(decoded)
	);

	// Writeback port doubles as the register file write
	regFile u_regFile (
		.clk(clk),
		.reset(reset),
		.rs1(rs1Idx),
		.rs2(rs2Idx),
		.rs1Val(rs1Val),
		.rs2Val(rs2Val),
		.wr(wb)
	);

	executeUnit u_executeUnit (
		.clk(clk),
		.reset(reset),
		.decoded(decoded),
		.redirect(branchRedirect),
		.wb(wb)
	);

endmodule

// File: hdl/executeUnit.sv
module executeUnit
	import rvCorePkg::*;
(
	input logic clk,
	input logic reset,
	input decodedInstr decoded,
	output rvCorePkg::redirect redirect,
	output regWrite wb
);

	word opA;
	word opB;
	word aluB;
	word aluOut;
	word result;
	logic condTrue;

	// Forward from the instruction one ahead, now in writeback
	always_comb begin
		if (wb.valid && wb.rd == decoded.rs1) begin
			opA = wb.data;
		end else begin
			opA = decoded.rs1Val;
		end
		if (wb.valid && wb.rd == decoded.rs2) begin
			opB = wb.data;
		end else begin
			opB = decoded.rs2Val;
		end
	end

	assign aluB = decoded.useImm ? decoded.imm : opB;

	always_comb begin
		case (decoded.aluOp)
			aluAdd: aluOut = opA + aluB;
			aluSub: aluOut = opA - aluB;
			aluAnd: aluOut = opA & aluB;
			aluOr: aluOut = opA | aluB;
			aluXor: aluOut = opA ^ aluB;
			aluSll: aluOut = opA << aluB[4:0];
			aluSrl: aluOut = opA >> aluB[4:0];
			aluSra: aluOut = word'($signed(opA) >>> aluB[4:0]);
			aluSlt: aluOut = {31'b0, $signed(opA) < $signed(aluB)};
			aluSltu: aluOut = {31'b0, opA < aluB};
			default: aluOut = opA + aluB;
		endcase
	end

	always_comb begin
		case (decoded.cond)
			brEq: condTrue = opA == opB;
			brNe: condTrue = opA != opB;
			brLt: condTrue = $signed(opA) < $signed(opB);
			default: condTrue = $signed(opA) >= $signed(opB);
		endcase
	end

	// Branch and jal targets are both pc relative
	assign redirect.taken = decoded.valid &&
		(decoded.isJump || (decoded.isBranch && condTrue));
	assign redirect.target = decoded.pc + decoded.imm;

	always_comb begin
		case (decoded.resultSel)
			resImm: result = decoded.imm;
			resLink: result = decoded.pc + 32'd4;
			default: result = aluOut;
		endcase
	end

	always_ff @(posedge clk) begin
		wb.rd <= decoded.rd;
		wb.data <= result;
		if (reset) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= decoded.valid && decoded.writeReg && decoded.rd != '0;
		end
	end

endmodule

// File: hdl/regFile.sv
module regFile
	import rvCorePkg::*;
(
	input logic clk,
	input logic reset,
	input regIdx rs1,
	input regIdx rs2,
	output word rs1Val,
	output word rs2Val,
	input regWrite wr
);

	word regs [1:31];

	// x0 reads zero, a same-cycle write is seen at once
	function automatic word readPort(input regIdx idx);
		if (idx == '0) begin
			readPort = '0;
		end else if (wr.valid && wr.rd == idx) begin
			readPort = wr.data;
		end else begin
			readPort = regs[idx];
		end
	endfunction

	always_comb begin
		rs1Val = readPort(rs1);
		rs2Val = readPort(rs2);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid && wr.rd != '0) begin
			regs[wr.rd] <= wr.data;
		end
	end

endmodule

// File: hdl/decodeUnit.sv
module decodeUnit
	import rvCorePkg::*;
(
	input logic clk,
	input logic reset,
	input fetchedInstr fetched,
	input rvCorePkg::redirect redirect,
	output regIdx rs1,
	output regIdx rs2,
	input word rs1Val,
	input word rs2Val,
	output decodedInstr decoded
);

	word instr;
	logic [2:0] funct3;
	word immI;
	word immU;
	word immB;
	word immJ;
	decodedInstr nextDecoded;

	// funct7 bit 30 picks sub and sra
	function automatic aluOpE aluFromFunct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: aluFromFunct = alt ? aluSub : aluAdd;
			3'b001: aluFromFunct = aluSll;
			3'b010: aluFromFunct = aluSlt;
			3'b011: aluFromFunct = aluSltu;
			3'b100: aluFromFunct = aluXor;
			3'b101: aluFromFunct = alt ? aluSra : aluSrl;
			3'b110: aluFromFunct = aluOr;
			default: aluFromFunct = aluAnd;
		endcase
	endfunction

	assign instr = fetched.instr;
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immU = {instr[31:12], 12'b0};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		nextDecoded = '0;
		nextDecoded.valid = fetched.valid;
		nextDecoded.pc = fetched.pc;
		nextDecoded.rs1 = rs1;
		nextDecoded.rs2 = rs2;
		nextDecoded.rd = instr[11:7];
		nextDecoded.rs1Val = rs1Val;
		nextDecoded.rs2Val = rs2Val;
		nextDecoded.aluOp = aluAdd;
		nextDecoded.cond = brEq;
		nextDecoded.resultSel = resAlu;
		case (instr[6:0])
			opReg: begin
				nextDecoded.aluOp = aluFromFunct(funct3, instr[30]);
				nextDecoded.writeReg = 1'b1;
			end
			opImm: begin
				// Only srai uses bit 30, addi never subtracts
				nextDecoded.aluOp = aluFromFunct(funct3, instr[30] && funct3 == 3'b101);
				nextDecoded.imm = immI;
				nextDecoded.useImm = 1'b1;
				nextDecoded.writeReg = 1'b1;
			end
			opLui: begin
				nextDecoded.imm = immU;
				nextDecoded.resultSel = resImm;
				nextDecoded.writeReg = 1'b1;
			end
			opJal: begin
				nextDecoded.imm = immJ;
				nextDecoded.isJump = 1'b1;
				nextDecoded.resultSel = resLink;
				nextDecoded.writeReg = 1'b1;
			end
			opBranch: begin
				nextDecoded.imm = immB;
				case (funct3)
					3'b000: nextDecoded.cond = brEq;
					3'b001: nextDecoded.cond = brNe;
					3'b100: nextDecoded.cond = brLt;
					default: nextDecoded.cond = brGe;
				endcase
				nextDecoded.isBranch = funct3 == 3'b000 || funct3 == 3'b001 ||
					funct3 == 3'b100 || funct3 == 3'b101;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		decoded <= nextDecoded;
		// Squash the younger instruction on a taken branch
		if (reset || redirect.taken) begin
			decoded.valid <= 1'b0;
		end
	end

endmodule

// File: hdl/fetchUnit.sv
module fetchUnit
	import rvCorePkg::*;
#(
	parameter word resetAddr = '0
) (
	input logic clk,
	input logic reset,
	input rvCorePkg::redirect redirect,
	input word imemData,
	output word imemAddr,
	output fetchedInstr fetched
);

	word pc;

	assign imemAddr = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetAddr;
		end else if (redirect.taken) begin
			pc <= redirect.target;
		end else begin
			pc <= pc + 32'd4;
		end
	end

	// Instruction memory answers in the same cycle
	always_ff @(posedge clk) begin
		fetched.pc <= pc;
		fetched.instr <= imemData;
		if (reset || redirect.taken) begin
			fetched.valid <= 1'b0;
		end else begin
			fetched.valid <= 1'b1;
		end
	end

endmodule

// File: hdl/rvCorePkg.sv
package rvCorePkg;

	localparam int xlen = 32;

	typedef logic [4:0] regIdx;
	typedef logic [xlen-1:0] word;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		opReg = 7'b0110011,
		opImm = 7'b0010011,
		opLui = 7'b0110111,
		opJal = 7'b1101111,
		opBranch = 7'b1100011
	} opcodeE;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSll,
		aluSrl,
		aluSra,
		aluSlt,
		aluSltu
	} aluOpE;

	typedef enum logic [1:0] {
		brEq,
		brNe,
		brLt,
		brGe
	} branchCondE;

	// Writeback source
	typedef enum logic [1:0] {
		resAlu,
		resImm,
		resLink
	} resultSelE;

	typedef struct packed {
		logic valid;
		word pc;
		word instr;
	} fetchedInstr;

	typedef struct packed {
		logic valid;
		word pc;
		regIdx rs1;
		regIdx rs2;
		regIdx rd;
		word rs1Val;
		word rs2Val;
		word imm;
		aluOpE aluOp;
		logic useImm;
		logic isBranch;
		logic isJump;
		branchCondE cond;
		resultSelE resultSel;
		logic writeReg;
	} decodedInstr;

	typedef struct packed {
		logic taken;
		word target;
	} redirect;

	typedef struct packed {
		logic valid;
		regIdx rd;
		word data;
	} regWrite;

endpackage
